// File: Makefile
.PHONY: all run lint clean

all: run

obj_dir/Vtb_top: tb.f *.sv
	verilator --binary --assert --top-module tb_top -f tb.f

run: obj_dir/Vtb_top
	./obj_dir/Vtb_top | tee sim.log
	grep -q "Simulation passed" sim.log

lint:
	verilator --lint-only -Wall --top-module revive_core revive_pkg.sv revive_alu.sv \
		revive_regfile.sv revive_fetch.sv revive_decode.sv revive_execute.sv revive_core.sv

clean:
	rm -rf obj_dir sim.log

// File: alu_trace.txt
# T name: start of a test; I word: next program word in hex, pc = index * 4
# E rd value: next expected retirement, rd in decimal, value in hex
T imm_ops
I 123450b7
E 1 12345000
I 00001117
E 2 00001004
I ffb00193
E 3 fffffffb
I ffc1a213
E 4 00000001
I 0051b293
E 5 00000000
I 0ff0c313
E 6 123450ff
I 7f00e393
E 7 123457f0
I 0f01f413
E 8 000000f0
I 00419493
E 9 ffffffb0
I 0041d513
E 10 0fffffff
I 4041d593
E 11 ffffffff
T reg_ops
I 00308633
E 12 12344ffb
I 401406b3
E 13 edcbb0f0
I 00941733
E 14 00f00000
I 0081a7b3
E 15 00000001
I 0081b833
E 16 00000000
I 0070c8b3
E 17 000007f0
I 0041d933
E 18 7ffffffd
I 4041d9b3
E 19 fffffffd
I 00446a33
E 20 000000f1
I 00737ab3
E 21 123450f0
T forwarding
I 00700b13
E 22 00000007
I 016b0bb3
E 23 0000000e
I 416b8c33
E 24 00000007
I 003b1c93
E 25 00000038
I 018ccb33
E 22 0000003f
I 017b0d33
E 26 0000004d
I fffd0d13
E 26 0000004c
I 000d6db3
E 27 0000004c
I 01b03e33
E 28 00000001
T bubbles
I 005b0013
I 01c00eb3
E 29 00000001
I 0ff0000f
I ffffffff
I 02108f33
I 002e8f13
E 30 00000003
T stall_order
I 001f8f93
E 31 00000001
I 001f8f93
E 31 00000002
I 001f8f93
E 31 00000003
I 001f8f93
E 31 00000004
I 001f8f93
E 31 00000005

// File: revive_alu.sv
`timescale 1ns/100ps

module revive_alu (
	input  revive_pkg::alu_op_t           aluop_i,
	input  logic [revive_pkg::W_DATA-1:0] op_a_i,
	input  logic [revive_pkg::W_DATA-1:0] op_b_i,
	output logic [revive_pkg::W_DATA-1:0] result_o
);
	import revive_pkg::*;

	logic [4:0] shamt;
	logic       lt_s;
	logic       lt_u;

	assign shamt = op_b_i[4:0];
	assign lt_s  = $signed(op_a_i) < $signed(op_b_i);
	assign lt_u  = op_a_i < op_b_i;

	always_comb begin
		case (aluop_i)
			ALU_ADD: result_o = op_a_i + op_b_i;
			ALU_SUB: result_o = op_a_i - op_b_i;
			ALU_SLL: result_o = op_a_i << shamt;
			ALU_LT:  result_o = {{(W_DATA-1){1'b0}}, lt_s};
			ALU_LTU: result_o = {{(W_DATA-1){1'b0}}, lt_u};
			ALU_XOR: result_o = op_a_i ^ op_b_i;
			ALU_SRL: result_o = op_a_i >> shamt;
			// Arithmetic shift keeps the sign bit
			ALU_SRA: result_o = $signed(op_a_i) >>> shamt;
			ALU_OR:  result_o = op_a_i | op_b_i;
			ALU_AND: result_o = op_a_i & op_b_i;
			default: result_o = '0;
		endcase
	end

endmodule

// File: revive_core.sv
`timescale 1ns/100ps

module revive_core (
	input  logic                             clk,
	input  logic                             rst_n,
	input  logic                             hready_i,
	input  logic [revive_pkg::W_DATA-1:0]    hrdata_i,
	output logic [1:0]                       htrans_o,
	output logic [revive_pkg::W_ADDR-1:0]    haddr_o,
	output logic                             retire_valid_o,
	output logic [revive_pkg::W_REGADDR-1:0] retire_rd_o,
	output logic [revive_pkg::W_DATA-1:0]    retire_data_o
);
	import revive_pkg::*;

	fd_instr_t            fd;
	dx_ctrl_t             dx;
	wb_t                  wb;
	logic [W_REGADDR-1:0] rs1;
	logic [W_REGADDR-1:0] rs2;
	logic [W_DATA-1:0]    rdata1;
	logic [W_DATA-1:0]    rdata2;

	// ==============================
	// F, D, X stages
	// ==============================

	revive_fetch fetch0 (
		.clk      (clk),
		.rst_n    (rst_n),
		.hready_i (hready_i),
		.hrdata_i (hrdata_i),
		.htrans_o (htrans_o),
		.haddr_o  (haddr_o),
		.fd_o     (fd)
	);

	revive_decode decode0 (
		.clk      (clk),
		.rst_n    (rst_n),
		.hready_i (hready_i),
		.fd_i     (fd),
		.rs1_o    (rs1),
		.rs2_o    (rs2),
		.dx_o     (dx)
	);

	revive_execute execute0 (
		.clk      (clk),
		.rst_n    (rst_n),
		.hready_i (hready_i),
		.dx_i     (dx),
		.rdata1_i (rdata1),
		.rdata2_i (rdata2),
		.wb_o     (wb)
	);

	// W stage is the regfile write and the trace port
	revive_regfile regfile0 (
		.clk      (clk),
		.rst_n    (rst_n),
		.raddr1_i (rs1),
		.raddr2_i (rs2),
		.rdata1_o (rdata1),
		.rdata2_o (rdata2),
		.wb_i     (wb)
	);

	assign retire_valid_o = |wb.rd;
	assign retire_rd_o    = wb.rd;
	assign retire_data_o  = wb.result;

endmodule

// File: revive_decode.sv
`timescale 1ns/100ps

module revive_decode (
	input  logic                             clk,
	input  logic                             rst_n,
	input  logic                             hready_i,
	input  revive_pkg::fd_instr_t            fd_i,
	output logic [revive_pkg::W_REGADDR-1:0] rs1_o,
	output logic [revive_pkg::W_REGADDR-1:0] rs2_o,
	output revive_pkg::dx_ctrl_t             dx_o
);
	import revive_pkg::*;

	logic [2:0]        funct3;
	logic [6:0]        funct7;
	logic [W_DATA-1:0] imm_i;
	logic [W_DATA-1:0] imm_u;
	logic              known;
	logic              alt;
	dx_ctrl_t          ctrl;

	function automatic alu_op_t alu_from_funct3(input logic [2:0] f3, input logic alt_sel);
		alu_op_t op;
		case (f3)
			3'b000:  op = alt_sel ? ALU_SUB : ALU_ADD;
			3'b001:  op = ALU_SLL;
			3'b010:  op = ALU_LT;
			3'b011:  op = ALU_LTU;
			3'b100:  op = ALU_XOR;
			3'b101:  op = alt_sel ? ALU_SRA : ALU_SRL;
			3'b110:  op = ALU_OR;
			default: op = ALU_AND;
		endcase
		return op;
	endfunction

	assign funct3 = fd_i.instr.r.funct3;
	assign funct7 = fd_i.instr.r.funct7;
	assign imm_i  = {{20{fd_i.instr.i.imm12[11]}}, fd_i.instr.i.imm12};
	assign imm_u  = {fd_i.instr.u.imm20, 12'h000};
	assign alt    = (funct7 == F7_ALT);

	// Register file is addressed straight from the fetched word
	assign rs1_o = fd_i.instr.r.rs1;
	assign rs2_o = fd_i.instr.r.rs2;

	always_comb begin
		known      = 1'b0;
		ctrl.rs1   = fd_i.instr.r.rs1;
		ctrl.rs2   = fd_i.instr.r.rs2;
		ctrl.rd    = fd_i.instr.r.rd;
		ctrl.imm   = imm_i;
		ctrl.pc    = fd_i.pc;
		ctrl.aluop = ALU_ADD;
		ctrl.srca  = SRCA_RS1;
		ctrl.srcb  = SRCB_RS2;
		case (fd_i.instr.r.opcode)
			OPC_LUI: begin
				known     = 1'b1;
				ctrl.imm  = imm_u;
				ctrl.srca = SRCA_ZERO;
				ctrl.srcb = SRCB_IMM;
			end
			OPC_AUIPC: begin
				known     = 1'b1;
				ctrl.imm  = imm_u;
				ctrl.srca = SRCA_PC;
				ctrl.srcb = SRCB_IMM;
			end
			OPC_OP_IMM: begin
				// Only the shifts put constraints on the upper immediate bits
				if (funct3 == 3'b001) begin
					known = (funct7 == F7_BASE);
				end else if (funct3 == 3'b101) begin
					known = (funct7 == F7_BASE) || alt;
				end else begin
					known = 1'b1;
				end
				ctrl.aluop = alu_from_funct3(funct3, alt && funct3 == 3'b101);
				ctrl.srcb  = SRCB_IMM;
			end
			OPC_OP: begin
				known = (funct7 == F7_BASE) || (alt && (funct3 == 3'b000 || funct3 == 3'b101));
				ctrl.aluop = alu_from_funct3(funct3, alt);
			end
			default: begin
				known = 1'b0;
			end
		endcase
		ctrl.valid = fd_i.valid && known;
		if (!ctrl.valid) begin
			ctrl.rd = '0;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			dx_o <= '0;
		end else if (hready_i) begin
			dx_o <= ctrl;
		end
	end

endmodule

// File: revive_execute.sv
`timescale 1ns/100ps

module revive_execute (
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic                          hready_i,
	input  revive_pkg::dx_ctrl_t          dx_i,
	input  logic [revive_pkg::W_DATA-1:0] rdata1_i,
	input  logic [revive_pkg::W_DATA-1:0] rdata2_i,
	output revive_pkg::wb_t               wb_o
);
	import revive_pkg::*;

	// Regfile data sampled as the instruction entered X
	logic [W_DATA-1:0] rdata1_q;
	logic [W_DATA-1:0] rdata2_q;
	logic [W_DATA-1:0] rs1_fwd;
	logic [W_DATA-1:0] rs2_fwd;
	logic [W_DATA-1:0] op_a;
	logic [W_DATA-1:0] op_b;
	logic [W_DATA-1:0] alu_result;
	wb_t               wb_q;
	// Write that landed in the regfile as the read data was sampled
	wb_t               wx_q;

	function automatic logic [W_DATA-1:0] forward(input logic [W_REGADDR-1:0] rs,
		input wb_t xw, input wb_t wx, input logic [W_DATA-1:0] rf_data);
		logic [W_DATA-1:0] val;
		if (rs == '0) begin
			val = '0;
		end else if (rs == xw.rd) begin
			val = xw.result;
		end else if (rs == wx.rd) begin
			val = wx.result;
		end else begin
			val = rf_data;
		end
		return val;
	endfunction

	always_ff @(posedge clk) begin
		if (hready_i) begin
			rdata1_q <= rdata1_i;
			rdata2_q <= rdata2_i;
		end
	end

	// ==============================
	// Operand select and ALU
	// ==============================

	assign rs1_fwd = forward(dx_i.rs1, wb_q, wx_q, rdata1_q);
	assign rs2_fwd = forward(dx_i.rs2, wb_q, wx_q, rdata2_q);

	always_comb begin
		case (dx_i.srca)
			SRCA_PC:   op_a = dx_i.pc;
			SRCA_ZERO: op_a = '0;
			default:   op_a = rs1_fwd;
		endcase
		op_b = (dx_i.srcb == SRCB_IMM) ? dx_i.imm : rs2_fwd;
	end

	revive_alu alu0 (
		.aluop_i  (dx_i.aluop),
		.op_a_i   (op_a),
		.op_b_i   (op_b),
		.result_o (alu_result)
	);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wb_q <= '0;
			wx_q <= '0;
		end else if (hready_i) begin
			wb_q.rd     <= dx_i.valid ? dx_i.rd : '0;
			wb_q.result <= alu_result;
			wx_q        <= wb_q;
		end
	end

	// Held result is shown only in its last cycle so it writes and retires once
	always_comb begin
		wb_o.rd     = hready_i ? wb_q.rd : '0;
		wb_o.result = wb_q.result;
	end

	// Decode hands over bubbles with no destination
	bubble_no_rd_a: assert property (@(posedge clk) disable iff (!rst_n)
		!dx_i.valid |-> dx_i.rd == '0);

endmodule

// File: revive_fetch.sv
`timescale 1ns/100ps

module revive_fetch (
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic                          hready_i,
	input  logic [revive_pkg::W_DATA-1:0] hrdata_i,
	output logic [1:0]                    htrans_o,
	output logic [revive_pkg::W_ADDR-1:0] haddr_o,
	output revive_pkg::fd_instr_t         fd_o
);
	import revive_pkg::*;

	logic [W_ADDR-1:0] haddr_q;
	// Address phase on the bus this cycle
	logic addr_pend_q;
	// Previous address phase was accepted, so its data phase runs now
	logic data_pend_q;

	// ==============================
	// Address phase
	// ==============================

	assign htrans_o = addr_pend_q ? HTRANS_NSEQ : HTRANS_IDLE;
	assign haddr_o  = haddr_q;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			haddr_q     <= RESET_VECTOR;
			addr_pend_q <= 1'b0;
			data_pend_q <= 1'b0;
			fd_o        <= '0;
		end else begin
			addr_pend_q <= 1'b1;
			if (hready_i) begin
				if (addr_pend_q) begin
					haddr_q <= haddr_q + W_ADDR'(4);
				end
				data_pend_q <= addr_pend_q;
				// Data phase ends here, haddr_q already points one word ahead
				fd_o.valid <= data_pend_q;
				fd_o.pc    <= haddr_q - W_ADDR'(4);
				fd_o.instr <= hrdata_i;
			end
		end
	end

	haddr_aligned_a: assert property (@(posedge clk) disable iff (!rst_n)
		htrans_o == HTRANS_NSEQ |-> haddr_o[1:0] == 2'b00);

endmodule

// File: revive_pkg.sv
package revive_pkg;

	// ==============================
	// Widths and bus codes
	// ==============================

	localparam int W_ADDR = 32;
	localparam int W_DATA = 32;
	localparam int N_REGS = 32;
	localparam int W_REGADDR = $clog2(N_REGS);

	localparam logic [W_ADDR-1:0] RESET_VECTOR = 32'h0000_0000;

	localparam logic [1:0] HTRANS_IDLE = 2'b00;
	localparam logic [1:0] HTRANS_NSEQ = 2'b10;

	// Major opcodes of the integer ALU group
	localparam logic [6:0] OPC_LUI    = 7'b0110111;
	localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
	localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
	localparam logic [6:0] OPC_OP     = 7'b0110011;

	// funct7 values, ALT selects SUB and SRA/SRAI
	localparam logic [6:0] F7_BASE = 7'b0000000;
	localparam logic [6:0] F7_ALT  = 7'b0100000;

	// ==============================
	// Execute controls
	// ==============================

	typedef enum logic [3:0] {
		ALU_ADD, ALU_SUB, ALU_SLL, ALU_LT, ALU_LTU,
		ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND
	} alu_op_t;

	typedef enum logic [1:0] {SRCA_RS1, SRCA_PC, SRCA_ZERO} alusrc_a_t;
	typedef enum logic {SRCB_RS2, SRCB_IMM} alusrc_b_t;

	// ==============================
	// Instruction word views
	// ==============================

	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} r_fmt_t;

	typedef struct packed {
		logic [11:0] imm12;
		logic [4:0]  rs1;
		logic [2:0]  funct3;
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} i_fmt_t;

	typedef struct packed {
		logic [19:0] imm20;
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} u_fmt_t;

	typedef union packed {
		r_fmt_t r;
		i_fmt_t i;
		u_fmt_t u;
	} instr_u;

	// Pipeline registers
	typedef struct packed {
		logic              valid;
		logic [W_ADDR-1:0] pc;
		instr_u            instr;
	} fd_instr_t;

	typedef struct packed {
		logic                 valid;
		logic [W_REGADDR-1:0] rs1;
		logic [W_REGADDR-1:0] rs2;
		logic [W_REGADDR-1:0] rd;
		logic [W_DATA-1:0]    imm;
		logic [W_ADDR-1:0]    pc;
		alu_op_t              aluop;
		alusrc_a_t            srca;
		alusrc_b_t            srcb;
	} dx_ctrl_t;

	typedef struct packed {
		logic [W_REGADDR-1:0] rd;
		logic [W_DATA-1:0]    result;
	} wb_t;

endpackage

// File: revive_regfile.sv
`timescale 1ns/100ps

module revive_regfile (
	input  logic                             clk,
	input  logic                             rst_n,
	input  logic [revive_pkg::W_REGADDR-1:0] raddr1_i,
	input  logic [revive_pkg::W_REGADDR-1:0] raddr2_i,
	output logic [revive_pkg::W_DATA-1:0]    rdata1_o,
	output logic [revive_pkg::W_DATA-1:0]    rdata2_o,
	input  revive_pkg::wb_t                  wb_i
);
	import revive_pkg::*;

	logic [W_DATA-1:0] regs [N_REGS];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < N_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wb_i.rd != '0) begin
			regs[wb_i.rd] <= wb_i.result;
		end
	end

	assign rdata1_o = regs[raddr1_i];
	assign rdata2_o = regs[raddr2_i];

	x0_zero_a: assert property (@(posedge clk) disable iff (!rst_n) regs[0] == '0);

endmodule

// File: tb.f
revive_pkg.sv
revive_alu.sv
revive_regfile.sv
revive_fetch.sv
revive_decode.sv
revive_execute.sv
revive_core.sv
tb_checker.sv
tb_top.sv

// File: tb_checker.sv
`timescale 1ns/100ps

module tb_checker (
	input  logic        clk,
	input  logic        rst_n,
	input  logic        retire_valid_i,
	input  logic [4:0]  retire_rd_i,
	input  logic [31:0] retire_data_i,
	output logic        done_o,
	output int          errors_o
);

	// Expected retirements in program order, tagged with their test
	string       exp_test [$];
	logic [4:0]  exp_rd [$];
	logic [31:0] exp_data [$];

	int   next_idx = 0;
	int   errors = 0;
	int   test_errors = 0;
	int   test_entries = 0;
	int   tests_passed = 0;
	int   tests_failed = 0;
	logic done = 1'b0;

	assign done_o   = done;
	assign errors_o = errors;

	task automatic add_expect(input string name, input logic [4:0] rd, input logic [31:0] data);
		exp_test.push_back(name);
		exp_rd.push_back(rd);
		exp_data.push_back(data);
	endtask

	task automatic note_failure(input string msg);
		$display("%s", msg);
		errors++;
	endtask

	task automatic report_counts();
		$display("Tests passed %0d, failed %0d; retirements checked %0d of %0d; errors %0d",
			tests_passed, tests_failed, next_idx, exp_rd.size(), errors);
	endtask

	task automatic close_test(input string name);
		if (test_errors == 0) begin
			$display("Test %s: ok, %0d retirements", name, test_entries);
			tests_passed++;
		end else begin
			$display("Test %s: %0d of %0d retirements wrong", name, test_errors, test_entries);
			tests_failed++;
		end
		test_errors  = 0;
		test_entries = 0;
	endtask

	// ==============================
	// Retire port compare
	// ==============================

	// Retire outputs settle after the rising edge, so look at them mid-cycle
	always @(negedge clk) begin
		if (rst_n && retire_valid_i) begin
			if (next_idx >= exp_rd.size()) begin
				$display("Unexpected retirement of x%0d = %08h after the last expected entry",
					retire_rd_i, retire_data_i);
				errors++;
			end else begin
				test_entries++;
				if (retire_rd_i !== exp_rd[next_idx] || retire_data_i !== exp_data[next_idx]) begin
					$display("Error %s: expected x%0d = %08h, actual x%0d = %08h",
						exp_test[next_idx], exp_rd[next_idx], exp_data[next_idx],
						retire_rd_i, retire_data_i);
					errors++;
					test_errors++;
				end
				// Last entry of a test closes it
				if (next_idx == exp_rd.size() - 1 || exp_test[next_idx + 1] != exp_test[next_idx]) begin
					close_test(exp_test[next_idx]);
				end
				next_idx++;
				done = (next_idx == exp_rd.size());
			end
		end
	end

endmodule

// File: tb_top.sv
`timescale 1ns/100ps

module tb_top;
	import revive_pkg::*;

	localparam int          RESET_CYCLES = 16;
	localparam int          DRAIN_CYCLES = 32;
	localparam logic [31:0] NOP_WORD     = 32'h0000_0013;
	localparam logic [31:0] LFSR_SEED    = 32'h520f_431a;

	logic        clk = 1'b0;
	logic        rst_n = 1'b0;
	logic        hready = 1'b1;
	logic [31:0] hrdata = NOP_WORD;
	logic [1:0]  htrans;
	logic [31:0] haddr;
	logic        retire_valid;
	logic [4:0]  retire_rd;
	logic [31:0] retire_data;
	logic        checks_done;
	int          error_count;

	logic [31:0] prog [$];
	logic [31:0] lfsr = LFSR_SEED;
	logic        trace_loaded = 1'b0;
	int          watchdog_cycles = 0;

	always #50 clk = ~clk;

	revive_core dut0 (
		.clk            (clk),
		.rst_n          (rst_n),
		.hready_i       (hready),
		.hrdata_i       (hrdata),
		.htrans_o       (htrans),
		.haddr_o        (haddr),
		.retire_valid_o (retire_valid),
		.retire_rd_o    (retire_rd),
		.retire_data_o  (retire_data)
	);

	tb_checker chk0 (
		.clk            (clk),
		.rst_n          (rst_n),
		.retire_valid_i (retire_valid),
		.retire_rd_i    (retire_rd),
		.retire_data_i  (retire_data),
		.done_o         (checks_done),
		.errors_o       (error_count)
	);

	// 32-bit Fibonacci LFSR, taps 32 22 2 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// Words past the end of the program read as NOP
	function automatic logic [31:0] fetch_word(input logic [31:0] addr);
		int idx;
		idx = int'(addr >> 2);
		if (idx < prog.size()) begin
			return prog[idx];
		end
		return NOP_WORD;
	endfunction

	function automatic string test_name(input string line);
		int last;
		last = line.len() - 1;
		while (last > 1 && (line[last] == "\n" || line[last] == "\r" || line[last] == " ")) begin
			last--;
		end
		return line.substr(2, last);
	endfunction

	task automatic load_trace();
		int          fd;
		int          rd;
		string       line;
		string       name;
		logic [31:0] value;
		fd = $fopen("alu_trace.txt", "r");
		if (fd == 0) begin
			$display("Cannot open alu_trace.txt for reading");
			$display("Simulation failed");
			$finish;
		end else begin
			name = "unnamed";
			while ($fgets(line, fd) != 0) begin
				case (line[0])
					"T": name = test_name(line);
					"I": begin
						void'($sscanf(line, "I %h", value));
						prog.push_back(value);
					end
					"E": begin
						void'($sscanf(line, "E %d %h", rd, value));
						chk0.add_expect(name, rd[4:0], value);
					end
					default: ;
				endcase
			end
			$fclose(fd);
		end
	endtask

	// ==============================
	// Reset and AHB memory model
	// ==============================

	initial begin : stimulus
		logic        accepted;
		logic [31:0] data_addr;
		logic [31:0] next_addr;
		logic        b0;
		logic        b1;
		load_trace();
		watchdog_cycles = prog.size() * 4 + 64;
		trace_loaded = 1'b1;
		next_addr = 32'h0000_0000;
		repeat (RESET_CYCLES) @(posedge clk);
		#1;
		rst_n = 1'b1;
		forever begin
			// Address phase is taken at the next edge when hready is high
			@(negedge clk);
			accepted  = hready && (htrans == HTRANS_NSEQ);
			data_addr = haddr;
			if (accepted) begin
				// Fetch addresses run word by word from the reset vector
				if (haddr !== next_addr) begin
					chk0.note_failure($sformatf(
						"Fetch went to address %08h when %08h was the next word",
						haddr, next_addr));
				end
				next_addr = next_addr + 32'd4;
			end
			@(posedge clk);
			#1;
			if (accepted) begin
				hrdata = fetch_word(data_addr);
			end
			// Low when both bits are set, about one cycle in four
			b0 = lfsr[31];
			lfsr = lfsr_next(lfsr);
			b1 = lfsr[31];
			lfsr = lfsr_next(lfsr);
			hready = !(b0 && b1);
		end
	end

	initial begin : watchdog
		wait (trace_loaded);
		repeat (watchdog_cycles) @(posedge clk);
		$display("Timeout: expected retirements still missing after %0d cycles", watchdog_cycles);
		chk0.report_counts();
		$display("Simulation failed");
		$finish;
	end

	initial begin : run_end
		wait (trace_loaded);
		wait (checks_done);
		// Give trailing words time to show any stray retirement
		repeat (DRAIN_CYCLES) @(negedge clk);
		chk0.report_counts();
		if (error_count == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule
